// ==== project.f ====
src/wb_bus_pkg.sv
src/wb_map_pkg.sv
src/wb_rr_arbiter.sv
src/wb_slave_port.sv
src/wb_master_port.sv
src/wb_decode_err_target.sv
src/wb_crossbar_3x4.sv
bench/wb_crossbar_properties.sv
bench/wb_crossbar_tb.sv

// ==== Makefile ====
TOOL       = verilator
TOP        = wb_crossbar_tb
FILELIST   = project.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run may stop with a nonzero status; the log search decides the result
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/wb_crossbar_tb.sv ====
// Fixed seed 10353; each master uses only words whose adr[6:5] equals its index, in every window
`default_nettype none
`timescale 1ns/1ps

module wb_crossbar_tb;

	logic clk = 1'b0;
	logic rstn;
	wb_bus_pkg::wb_req_t m_req [wb_map_pkg::N_MASTERS];
	wb_bus_pkg::wb_rsp_t m_rsp [wb_map_pkg::N_MASTERS];
	wb_bus_pkg::wb_req_t s_req [wb_map_pkg::N_SLAVES];
	wb_bus_pkg::wb_rsp_t s_rsp [wb_map_pkg::N_SLAVES] = '{default: '0};
	int seed = 10353;
	// Slave memories and the reference copy hold 32 words per window
	logic [31:0] mem [wb_map_pkg::N_SLAVES][32];
	logic [31:0] ref_mem [wb_map_pkg::N_SLAVES][32];
	// Slave model state
	logic active [wb_map_pkg::N_SLAVES];
	int wait_left [wb_map_pkg::N_SLAVES];
	// Acks given per slave feed the fairness bound
	int done_cnt [wb_map_pkg::N_SLAVES];
	// Target each master is addressing right now
	int exp_tgt [wb_map_pkg::N_MASTERS];

	wb_crossbar_3x4 dut_i (.clk(clk), .rstn(rstn), .m_req_i(m_req), .m_rsp_o(m_rsp),
		.s_req_o(s_req), .s_rsp_i(s_rsp));

	bind wb_crossbar_3x4 wb_crossbar_properties props_i (.clk(clk), .rstn(rstn),
		.m_rsp_i(m_rsp_o), .s_req_i(s_req_o));

	always #10 clk = ~clk;

	task automatic stop_on_failure();
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_rsp(input wb_bus_pkg::wb_rsp_t got, input wb_bus_pkg::wb_rsp_t want,
		input string name);
		if (got !== want) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, want);
			stop_on_failure();
		end
	endtask

	task automatic check_req(input wb_bus_pkg::wb_req_t got, input wb_bus_pkg::wb_req_t want,
		input string name);
		if (got !== want) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, want);
			stop_on_failure();
		end
	endtask

	// Slave models wait 0 to 3 cycles and then ack for one cycle
	always @(posedge clk) begin : slave_models
		int w;
		int idx;
		int m;
		for (int s = 0; s < wb_map_pkg::N_SLAVES; s++) begin
			idx = int'(s_req[s].adr[6:2]);
			m = int'(s_req[s].adr[6:5]);
			if (!rstn) begin
				s_rsp[s] <= '0;
				active[s] <= 1'b0;
				wait_left[s] <= 0;
				done_cnt[s] <= 0;
				// Fill depends on the full byte address
				for (int k = 0; k < 32; k++)
					mem[s][k] = (wb_map_pkg::WIN_BASE[s] + 32'(k) * 4) ^ 32'h5a5a_5a5a;
			end else if (s_rsp[s].ack) begin
				s_rsp[s] <= '0;
			end else if (s_req[s].cyc && s_req[s].stb) begin
				if (!active[s]) begin
					// The first strobe cycle is checked for routing and the exact request
					if (m >= wb_map_pkg::N_MASTERS || exp_tgt[m] != s) begin
						$display("Slave %0d got a strobe that was not addressed to it", s);
						stop_on_failure();
					end
					check_req(s_req[s], m_req[m], $sformatf("s_req_o[%0d]", s));
					w = $random(seed) & 3;
				end else begin
					w = wait_left[s];
				end
				if (w == 0) begin
					s_rsp[s].ack <= 1'b1;
					s_rsp[s].dat_r <= s_req[s].we ? 32'h0 : mem[s][idx];
					for (int b = 0; b < 4; b++)
						if (s_req[s].we && s_req[s].sel[b])
							mem[s][idx][8*b +: 8] = s_req[s].dat_w[8*b +: 8];
					active[s] <= 1'b0;
					done_cnt[s] <= done_cnt[s] + 1;
				end else begin
					active[s] <= 1'b1;
					wait_left[s] <= w - 1;
				end
			end
		end
	end

	// Bound assertion failures end the run as well
	always @(negedge clk) begin
		if (dut_i.props_i.fail_count != 0) begin
			$display("A concurrent assertion on the DUT ports failed");
			stop_on_failure();
		end
	end

	// One master writes and then reads back each word
	// The last quarter goes to slave 2 only
	task automatic run_master(input int m);
		wb_bus_pkg::wb_req_t req;
		wb_bus_pkg::wb_rsp_t want;
		logic [31:0] r;
		logic [31:0] ofs;
		int tgt;
		int idx;
		int start_cnt;
		int cycles;
		for (int n = 0; n < 64; n++) begin
			r = $random(seed);
			ofs = $random(seed);
			// Even steps open a new address, odd steps read it back
			if (n % 2 == 0) begin
				tgt = (n >= 48) ? 2 : ((r[6:4] == 3'd0) ? wb_map_pkg::ERR_TARGET : int'(r[1:0]));
				req = '0;
				req.adr = {25'h0, m[1:0], r[9:7], 2'b00};
				// Random upper offset bits reach anywhere inside the window
				if (tgt != wb_map_pkg::ERR_TARGET) begin
					req.adr = req.adr + wb_map_pkg::WIN_BASE[tgt] + (ofs & ~32'h7f &
						(wb_map_pkg::WIN_LIMIT[tgt] - wb_map_pkg::WIN_BASE[tgt]));
				end else begin
					case (r[11:10])
						2'd0: req.adr = req.adr + 32'h0000_2000;
						2'd1: req.adr = req.adr + 32'h0002_0000;
						2'd2: req.adr = req.adr + 32'h8000_0100;
						default: req.adr = req.adr + 32'h4000_0000;
					endcase
				end
				req.dat_w = $random(seed);
				req.we = 1'b1;
			end else begin
				req.dat_w = '0;
				req.we = 1'b0;
			end
			req.sel = r[15:12];
			// CTI and BTE only need to arrive unchanged
			req.cti = r[18:16];
			req.bte = r[20:19];
			req.cyc = 1'b1;
			req.stb = 1'b1;
			idx = int'(req.adr[6:2]);
			exp_tgt[m] = tgt;
			@(posedge clk);
			m_req[m] <= req;
			@(negedge clk);
			start_cnt = (tgt == wb_map_pkg::ERR_TARGET) ? 0 : done_cnt[tgt];
			cycles = 0;
			while (!m_rsp[m].ack && !m_rsp[m].err) begin
				if (cycles == 200) begin
					$display("Master %0d timed out waiting for ack or err", m);
					stop_on_failure();
				end
				cycles++;
				@(negedge clk);
			end
			want = '0;
			if (tgt == wb_map_pkg::ERR_TARGET) begin
				want.err = 1'b1;
			end else begin
				want.ack = 1'b1;
				if (!req.we)
					want.dat_r = ref_mem[tgt][idx];
				for (int b = 0; b < 4; b++)
					if (req.we && req.sel[b])
						ref_mem[tgt][idx][8*b +: 8] = req.dat_w[8*b +: 8];
				// Own transfer plus at most two others
				if (done_cnt[tgt] - start_cnt > 3) begin
					$display("Master %0d waited through more than two other transfers", m);
					stop_on_failure();
				end
			end
			check_rsp(m_rsp[m], want, $sformatf("m_rsp_o[%0d]", m));
		end
		@(posedge clk);
		m_req[m] <= '0;
	endtask

	initial begin
		rstn <= 1'b0;
		for (int m = 0; m < wb_map_pkg::N_MASTERS; m++)
			m_req[m] <= '0;
		for (int s = 0; s < wb_map_pkg::N_SLAVES; s++)
			for (int k = 0; k < 32; k++)
				ref_mem[s][k] = (wb_map_pkg::WIN_BASE[s] + 32'(k) * 4) ^ 32'h5a5a_5a5a;
		repeat (5) @(posedge clk);
		rstn <= 1'b1;
		// Quiet bus until a master requests
		repeat (3) begin
			@(negedge clk);
			for (int m = 0; m < wb_map_pkg::N_MASTERS; m++)
				check_rsp(m_rsp[m], '0, $sformatf("m_rsp_o[%0d]", m));
			for (int s = 0; s < wb_map_pkg::N_SLAVES; s++)
				check_req(s_req[s], '0, $sformatf("s_req_o[%0d]", s));
		end
		fork
			run_master(0);
			run_master(1);
			run_master(2);
		join
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/wb_crossbar_properties.sv ====
// Checks only the crossbar ports; fail_count is read by the testbench to end the run
`default_nettype none
`timescale 1ns/1ps

module wb_crossbar_properties (
	input  logic                clk,
	input  logic                rstn,
	input  wb_bus_pkg::wb_rsp_t m_rsp_i [wb_map_pkg::N_MASTERS],
	input  wb_bus_pkg::wb_req_t s_req_i [wb_map_pkg::N_SLAVES]
);

	// Number of assertion failures so far
	int unsigned fail_count = 0;

	// A response terminates one way only
	for (genvar m = 0; m < wb_map_pkg::N_MASTERS; m++) begin : g_mst
		ack_err_excl: assert property (@(posedge clk) !(m_rsp_i[m].ack && m_rsp_i[m].err))
			else begin
				$error("ack and err high together on m_rsp_o[%0d]", m);
				fail_count++;
			end
	end

	for (genvar s = 0; s < wb_map_pkg::N_SLAVES; s++) begin : g_slv
		// Strobe only inside a bus cycle
		stb_in_cyc: assert property (@(posedge clk) s_req_i[s].stb |-> s_req_i[s].cyc)
			else begin
				$error("stb without cyc on s_req_o[%0d]", s);
				fail_count++;
			end
		// Reset clears every slave strobe by the next edge
		stb_after_rst: assert property (@(posedge clk) !rstn |=> !s_req_i[s].stb)
			else begin
				$error("stb high on s_req_o[%0d] after a reset edge", s);
				fail_count++;
			end
	end

endmodule

`default_nettype wire

// ==== src/wb_crossbar_3x4.sv ====
// Three masters to four fixed windows plus an ERR target; at least two cycles from master to slave
`default_nettype none
`timescale 1ns/1ps

module wb_crossbar_3x4 (
	input  logic                clk,
	input  logic                rstn,
	input  wb_bus_pkg::wb_req_t m_req_i [wb_map_pkg::N_MASTERS],
	output wb_bus_pkg::wb_rsp_t m_rsp_o [wb_map_pkg::N_MASTERS],
	output wb_bus_pkg::wb_req_t s_req_o [wb_map_pkg::N_SLAVES],
	input  wb_bus_pkg::wb_rsp_t s_rsp_i [wb_map_pkg::N_SLAVES]
);

	// Per master, request line to each target
	logic [wb_map_pkg::N_TARGETS-1:0] mst_tgt_req [wb_map_pkg::N_MASTERS];
	// Per master, its grant bit from each target
	logic [wb_map_pkg::N_TARGETS-1:0] mst_tgt_gnt [wb_map_pkg::N_MASTERS];
	// Per target, request and grant vectors over the masters
	wb_map_pkg::master_vec_t tgt_req_vec [wb_map_pkg::N_TARGETS];
	wb_map_pkg::master_vec_t tgt_gnt_vec [wb_map_pkg::N_TARGETS];
	// Target side buses, slaves first then the error target
	wb_bus_pkg::wb_req_t tgt_req [wb_map_pkg::N_TARGETS];
	wb_bus_pkg::wb_rsp_t tgt_rsp [wb_map_pkg::N_TARGETS];

	for (genvar m = 0; m < wb_map_pkg::N_MASTERS; m++) begin : g_mst
		wb_master_port mst_i (.clk(clk), .rstn(rstn), .req_i(m_req_i[m]), .tgt_rsp_i(tgt_rsp),
			.tgt_gnt_i(mst_tgt_gnt[m]), .tgt_req_o(mst_tgt_req[m]), .rsp_o(m_rsp_o[m]));
		// Transpose master-major bits into target-major vectors and back
		for (genvar t = 0; t < wb_map_pkg::N_TARGETS; t++) begin : g_bit
			assign tgt_req_vec[t][m] = mst_tgt_req[m][t];
			assign mst_tgt_gnt[m][t] = tgt_gnt_vec[t][m];
		end
	end

	// Error target gets an arbiter too, so concurrent bad addresses serialize
	for (genvar t = 0; t < wb_map_pkg::N_TARGETS; t++) begin : g_tgt
		wb_slave_port slv_i (.clk(clk), .rstn(rstn), .mst_req_i(m_req_i),
			.req_vec_i(tgt_req_vec[t]), .gnt_o(tgt_gnt_vec[t]), .req_o(tgt_req[t]));
	end

	// External slaves occupy targets 0 to 3
	for (genvar s = 0; s < wb_map_pkg::N_SLAVES; s++) begin : g_slv
		assign s_req_o[s] = tgt_req[s];
		assign tgt_rsp[s] = s_rsp_i[s];
	end

	wb_decode_err_target err_i (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (tgt_req[wb_map_pkg::ERR_TARGET]),
		.rsp_o (tgt_rsp[wb_map_pkg::ERR_TARGET])
	);

endmodule

`default_nettype wire

// ==== src/wb_decode_err_target.sv ====
// Answers every strobe with a one-cycle ERR and zero data; never ACKs and ignores writes
`default_nettype none
`timescale 1ns/1ps

module wb_decode_err_target (
	input  logic                clk,
	input  logic                rstn,
	// Request routed from an unmapped address
	input  wb_bus_pkg::wb_req_t req_i,
	// Always an error response
	output wb_bus_pkg::wb_rsp_t rsp_o
);

	// Error pulse, one cycle after the strobe
	logic err_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			// The !err_q term keeps the pulse at one cycle
			// while the request is still visible in the err cycle
			err_q <= req_i.cyc && req_i.stb && !err_q;
		end
	end

	// No data and no ack
	always_comb begin
		rsp_o       = '0;
		rsp_o.err   = err_q;
	end

endmodule

`default_nettype wire

// ==== src/wb_master_port.sv ====
// Master must hold its request until ACK or ERR; dropping CYC early leaves the selection pending
`default_nettype none
`timescale 1ns/1ps

module wb_master_port (
	input  logic                                clk,
	input  logic                                rstn,
	// Request from the attached master
	input  wb_bus_pkg::wb_req_t                 req_i,
	// Responses from every target
	input  wb_bus_pkg::wb_rsp_t                 tgt_rsp_i [wb_map_pkg::N_TARGETS],
	// This master's grant bit from each target
	input  logic [wb_map_pkg::N_TARGETS-1:0]    tgt_gnt_i,
	// Request line towards each target
	output logic [wb_map_pkg::N_TARGETS-1:0]    tgt_req_o,
	// Response returned to the master
	output wb_bus_pkg::wb_rsp_t                 rsp_o
);

	// Transfer in progress
	logic busy_q;

	// Target decoded at the start of the cycle
	wb_map_pkg::target_id_t sel_q;

	// Start of a new transfer
	logic start;

	// Transfer terminated by the owning target
	logic done;

	assign start = !busy_q && req_i.cyc && req_i.stb;
	assign done  = busy_q && (rsp_o.ack || rsp_o.err);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy_q <= 1'b0;
			sel_q  <= '0;
		end else if (start) begin
			busy_q <= 1'b1;
			sel_q  <= wb_map_pkg::decode_target(req_i.adr);
		end else if (done) begin
			// Release on err as well, otherwise unmapped cycles never end
			busy_q <= 1'b0;
		end
	end

	// Exactly one request line while busy
	always_comb begin
		tgt_req_o = '0;
		for (int t = 0; t < wb_map_pkg::N_TARGETS; t++) begin
			tgt_req_o[t] = busy_q && (sel_q == wb_map_pkg::target_id_t'(t));
		end
	end

	// Response return select
	always_comb begin
		rsp_o = '0;
		// Only pass through once this master owns the selected target
		for (int t = 0; t < wb_map_pkg::N_TARGETS; t++) begin
			if (tgt_req_o[t] && tgt_gnt_i[t]) begin
				rsp_o = tgt_rsp_i[t];
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/wb_slave_port.sv ====
// One arbiter and request mux per target; request is forced to zero without a live grant
`default_nettype none
`timescale 1ns/1ps

module wb_slave_port (
	input  logic                    clk,
	input  logic                    rstn,
	// Raw requests from every master
	input  wb_bus_pkg::wb_req_t     mst_req_i [wb_map_pkg::N_MASTERS],
	// Masters whose selection points at this target
	input  wb_map_pkg::master_vec_t req_vec_i,
	// One-hot grant back to the master ports
	output wb_map_pkg::master_vec_t gnt_o,
	// Request as seen by the target
	output wb_bus_pkg::wb_req_t     req_o
);

	// Held grant from the arbiter
	wb_map_pkg::master_vec_t gnt;

	// Grant whose owner still requests this target
	wb_map_pkg::master_vec_t live;

	// Round-robin over the masters that selected this target
	wb_rr_arbiter arb_i (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (req_vec_i),
		.gnt_o (gnt)
	);

	// The grant lingers one cycle after completion
	// masking with the request bit hides that stale cycle from the slave
	assign live = gnt & req_vec_i;

	// Response routing in the master ports works off the held grant
	assign gnt_o = gnt;

	// Request mux
	always_comb begin
		req_o = '0;
		// live is one-hot or zero, so at most one branch is taken
		for (int m = 0; m < wb_map_pkg::N_MASTERS; m++) begin
			if (live[m]) begin
				req_o = mst_req_i[m];
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/wb_rr_arbiter.sv ====
// Grant appears one cycle after request and is held until that request falls; one grant at a time
`default_nettype none
`timescale 1ns/1ps

module wb_rr_arbiter (
	input  logic                    clk,
	input  logic                    rstn,
	input  wb_map_pkg::master_vec_t req_i,
	output wb_map_pkg::master_vec_t gnt_o
);

	// Current one-hot grant, zero when idle
	wb_map_pkg::master_vec_t gnt_q;

	// Most recent grant, kept after release for the rotation
	wb_map_pkg::master_vec_t last_q;

	// Bits strictly above the last grant
	wb_map_pkg::master_vec_t above_last;

	// Requests that win under rotation
	wb_map_pkg::master_vec_t masked_req;

	// Winner for the next grant, one-hot or zero
	wb_map_pkg::master_vec_t pick;

	// Running OR over lower bits of last_q
	logic seen;

	// Thermometer mask from the last grant upwards
	always_comb begin
		seen = 1'b0;
		for (int i = 0; i < wb_map_pkg::N_MASTERS; i++) begin
			above_last[i] = seen;
			seen = seen | last_q[i];
		end
	end

	assign masked_req = req_i & above_last;

	// Lowest requester above the last grant, else lowest requester overall
	always_comb begin
		if (|masked_req) begin
			// x & -x isolates the lowest set bit
			pick = masked_req & (~masked_req + wb_map_pkg::master_vec_t'(1));
		end else begin
			pick = req_i & (~req_i + wb_map_pkg::master_vec_t'(1));
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_q  <= '0;
			last_q <= '0;
		end else if (gnt_q == '0) begin
			// Idle, take a new winner if anyone asks
			if (|pick) begin
				gnt_q  <= pick;
				last_q <= pick;
			end
		end else if ((gnt_q & req_i) == '0) begin
			// Owner released its request
			// next arbitration happens from idle, one cycle later
			gnt_q <= '0;
		end
	end

	assign gnt_o = gnt_q;

endmodule

`default_nettype wire

// ==== src/wb_map_pkg.sv ====
// Fixed 3 master by 4 slave map; windows are inclusive, must not be reordered, first match wins
`default_nettype none

package wb_map_pkg;

	// Topology
	localparam int N_MASTERS = 3;
	localparam int N_SLAVES  = 4;

	// Four slaves plus the internal decode-error target
	localparam int N_TARGETS  = N_SLAVES + 1;
	localparam int ERR_TARGET = N_SLAVES;

	// Index of one target, wide enough for the error target
	typedef logic [$clog2(N_TARGETS)-1:0] target_id_t;

	// One bit per master, used for requests and one-hot grants
	typedef logic [N_MASTERS-1:0] master_vec_t;

	// Window base addresses per slave
	localparam logic [wb_bus_pkg::ADDR_W-1:0] WIN_BASE [N_SLAVES] = '{
		32'h0000_0000,
		32'h0000_1000,
		32'h0001_0000,
		32'h8000_0000
	};

	// Window limits, inclusive
	localparam logic [wb_bus_pkg::ADDR_W-1:0] WIN_LIMIT [N_SLAVES] = '{
		32'h0000_0FFF,
		32'h0000_1FFF,
		32'h0001_FFFF,
		32'h8000_00FF
	};

	// Address to target index, error target when no window matches
	function automatic target_id_t decode_target(input logic [wb_bus_pkg::ADDR_W-1:0] adr);
		target_id_t tgt;
		tgt = target_id_t'(ERR_TARGET);
		// Walk downwards so the lowest matching window is the one kept
		for (int i = N_SLAVES - 1; i >= 0; i--) begin
			if (adr >= WIN_BASE[i] && adr <= WIN_LIMIT[i]) begin
				tgt = target_id_t'(i);
			end
		end
		return tgt;
	endfunction

endpackage

`default_nettype wire

// ==== src/wb_bus_pkg.sv ====
// Wishbone B4 classic formats only; pipelined mode, tags and stall are not carried
`default_nettype none

package wb_bus_pkg;

	// Address and data bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// One select bit per byte lane
	localparam int SEL_W = DATA_W / 8;

	// Registered feedback fields, passed through untouched
	localparam int CTI_W = 3;
	localparam int BTE_W = 2;

	// Master to slave signals, 76 bits
	typedef struct packed {
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat_w;
		// Byte enables for writes and reads
		logic [SEL_W-1:0]  sel;
		logic              we;
		// Bus cycle in progress
		logic              cyc;
		// Valid data transfer
		logic              stb;
		// Cycle type identifier
		logic [CTI_W-1:0]  cti;
		// Burst type extension
		logic [BTE_W-1:0]  bte;
	} wb_req_t;

	// Slave to master signals, 34 bits
	typedef struct packed {
		logic [DATA_W-1:0] dat_r;
		// Normal termination
		logic              ack;
		// Abnormal termination, data is not valid
		logic              err;
	} wb_rsp_t;

endpackage

`default_nettype wire
